// ==== source/gmii_pkt_pkg.sv ====
// shared beat, byte and command types plus design constants, referenced by scoped names
package gmii_pkt_pkg;

	// ------------------------------------------------------------------------
	// sizes and addresses
	// ------------------------------------------------------------------------
	localparam int WORD_BYTES = 4;                       // bytes per beat
	localparam logic [47:0] CHIP_MAC = 48'h888888888888; // our own address
	localparam logic [47:0] HOST_MAC = 48'h00005e000101; // dst of every reply
	localparam int REG_COUNT = 16;                       // register table depth
	localparam int REG_ADDR_W = $clog2(REG_COUNT);       // table index bits
	localparam int CTRL_BEATS = 4;                       // 2 header + 2 command

	// beat position, same codes as the wide bus: 10 head, 00 body, 01 tail
	typedef enum logic [1:0] {
		POS_BODY   = 2'b00,
		POS_TAIL   = 2'b01,
		POS_HEAD   = 2'b10,
		POS_SINGLE = 2'b11  // head and tail in one beat
	} pos_t;

	// one 32-bit beat, first byte of the packet in data[31:24]
	typedef struct packed {
		pos_t        pos;
		logic [1:0]  empty; // unused low bytes, only on tail or single
		logic [31:0] data;
	} beat_t;

	// one byte on the rx or tx side
	typedef struct packed {
		logic [7:0] data;
		logic       last;   // final byte of the packet
	} byte_t;

	// ------------------------------------------------------------------------
	// register command, request and result share this layout
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic [2:0]  seq;   // 100 = first and end, the only form handled
		logic        ok;    // result only: address hit the table
		logic        write; // 0 read, 1 write
		logic [6:0]  mdid;  // carried and echoed
		logic [19:0] addr;
		logic [31:0] data;
	} cmd_word_t;

endpackage

// ==== source/byte_to_beat_packer.sv ====
// rx side width converter, packs the byte stream into 32-bit beats with position marks
`timescale 1ns/1ps

module byte_to_beat_packer (
	input  logic                 i_sys_clk,
	input  logic                 i_reset,
	input  gmii_pkt_pkg::byte_t  i_byte,
	input  logic                 i_byte_valid,
	output logic                 o_byte_ready,
	output gmii_pkt_pkg::beat_t  o_beat,
	output logic                 o_beat_valid,
	input  logic                 i_beat_ready
);

	logic [23:0] r_acc;  // bytes collected so far, right aligned
	logic [1:0]  r_cnt;  // how many are in r_acc
	logic        r_sop;  // next beat opens a packet
	logic [31:0] w_raw;
	logic [1:0]  w_pad;  // free byte slots if the beat closes now
	logic        w_take;
	logic        w_end;

	assign o_byte_ready = !o_beat_valid || i_beat_ready; // empty or draining
	assign w_take = i_byte_valid && o_byte_ready;
	assign w_raw = {r_acc, i_byte.data};
	assign w_pad = 2'(gmii_pkt_pkg::WORD_BYTES - 1 - r_cnt);
	assign w_end = i_byte.last || (r_cnt == 2'(gmii_pkt_pkg::WORD_BYTES - 1));

	always_ff @(posedge i_sys_clk) begin
		if (i_reset) begin
			r_cnt <= '0;
			r_sop <= 1'b1;
			o_beat_valid <= 1'b0;
		end else begin
			if (i_beat_ready)
				o_beat_valid <= 1'b0; // beat taken downstream
			if (w_take) begin
				r_cnt <= w_end ? 2'd0 : r_cnt + 2'd1;
				if (w_end) begin
					o_beat_valid <= 1'b1;
					r_sop <= i_byte.last; // a new packet follows the last byte
				end
			end
		end
	end

	// payload, no reset
	always_ff @(posedge i_sys_clk) begin
		if (w_take) begin
			r_acc <= w_raw[23:0];
			if (w_end) begin
				o_beat.data <= w_raw << {w_pad, 3'b000}; // first byte to the top
				o_beat.empty <= i_byte.last ? w_pad : 2'd0;
				if (r_sop)
					o_beat.pos <= i_byte.last ? gmii_pkt_pkg::POS_SINGLE : gmii_pkt_pkg::POS_HEAD;
				else
					o_beat.pos <= i_byte.last ? gmii_pkt_pkg::POS_TAIL : gmii_pkt_pkg::POS_BODY;
			end
		end
	end

	// a short beat may only close a packet
	a_empty_at_end: assert property (@(posedge i_sys_clk) disable iff (i_reset)
		o_beat_valid && (o_beat.pos inside {gmii_pkt_pkg::POS_HEAD, gmii_pkt_pkg::POS_BODY})
		|-> o_beat.empty == 2'd0);

endmodule

// ==== source/pkt_preparser.sv ====
// splits packets on the destination MAC, chip address to the control path, rest to data
`timescale 1ns/1ps

module pkt_preparser (
	input  logic                 i_sys_clk,
	input  logic                 i_reset,
	input  gmii_pkt_pkg::beat_t  i_beat,
	input  logic                 i_beat_valid,
	output logic                 o_beat_ready,
	output gmii_pkt_pkg::beat_t  o_ctrl,
	output logic                 o_ctrl_valid,
	input  logic                 i_ctrl_ready,
	output gmii_pkt_pkg::beat_t  o_data,
	output logic                 o_data_valid,
	input  logic                 i_data_ready
);

	gmii_pkt_pkg::beat_t r_held; // head beat waiting for the rest of the MAC
	gmii_pkt_pkg::beat_t r_out;  // single output register, shared by both ports
	logic r_held_valid;
	logic r_steer;      // inside a classified packet
	logic r_route;      // 1 control, 0 data, fixed until the tail
	logic r_out_valid;
	logic r_out_ctrl;   // which port r_out is offered on
	logic w_out_take;
	logic w_out_free;
	logic w_match;
	logic w_idle_head;
	logic w_take;

	assign o_ctrl = r_out;
	assign o_data = r_out;
	assign o_ctrl_valid = r_out_valid && r_out_ctrl;
	assign o_data_valid = r_out_valid && !r_out_ctrl;

	assign w_out_take = r_out_valid && (r_out_ctrl ? i_ctrl_ready : i_data_ready);
	assign w_out_free = !r_out_valid || w_out_take;
	// 4 MAC bytes in the head, last 2 in the top of beat 1 (looked at, not taken yet)
	assign w_match = (r_held.data == gmii_pkt_pkg::CHIP_MAC[47:16]) &&
		(i_beat.data[31:16] == gmii_pkt_pkg::CHIP_MAC[15:0]);
	assign w_idle_head = !r_steer && !r_held_valid && (i_beat.pos == gmii_pkt_pkg::POS_HEAD);
	assign o_beat_ready = !r_held_valid && (w_idle_head || w_out_free);
	assign w_take = i_beat_valid && o_beat_ready;

	always_ff @(posedge i_sys_clk) begin
		if (i_reset) begin
			r_held_valid <= 1'b0;
			r_steer <= 1'b0;
			r_route <= 1'b0;
			r_out_valid <= 1'b0;
			r_out_ctrl <= 1'b0;
		end else begin
			if (w_out_take)
				r_out_valid <= 1'b0;
			if (r_held_valid) begin
				if (i_beat_valid && w_out_free) begin // classify, release the head
					r_out_valid <= 1'b1;
					r_out_ctrl <= w_match;
					r_route <= w_match;
					r_steer <= 1'b1;
					r_held_valid <= 1'b0;
				end
			end else if (w_take) begin
				if (w_idle_head) begin
					r_held_valid <= 1'b1;
				end else begin
					r_out_valid <= 1'b1;
					r_out_ctrl <= r_steer && r_route; // lone beats go to data
					if (i_beat.pos inside {gmii_pkt_pkg::POS_TAIL, gmii_pkt_pkg::POS_SINGLE})
						r_steer <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge i_sys_clk) begin
		if (w_take && w_idle_head)
			r_held <= i_beat;
		else if (w_take)
			r_out <= i_beat;
		else if (r_held_valid && i_beat_valid && w_out_free)
			r_out <= r_held;
	end

endmodule

// ==== source/ctrl_cmd_engine.sv ====
// runs the single register command of a control packet and builds the reply packet
`timescale 1ns/1ps

module ctrl_cmd_engine (
	input  logic                 i_sys_clk,
	input  logic                 i_reset,
	input  gmii_pkt_pkg::beat_t  i_ctrl,
	input  logic                 i_ctrl_valid,
	output logic                 o_ctrl_ready,
	output gmii_pkt_pkg::beat_t  o_reply,
	output logic                 o_reply_valid,
	input  logic                 i_reply_ready
);

	logic [31:0] r_regs [gmii_pkt_pkg::REG_COUNT]; // the register table
	logic [31:0] r_req_hi;            // upper command half from beat 2
	logic [2:0]  r_cnt;               // saturating count of beats in this packet
	logic [2:0]  w_idx;               // index of the beat on the bus
	logic [1:0]  r_rcnt;              // reply beat being offered
	logic        r_busy;              // reply pending
	gmii_pkt_pkg::cmd_word_t w_req;
	gmii_pkt_pkg::cmd_word_t r_res;
	logic w_take;
	logic w_exec;
	logic w_ok;

	assign o_ctrl_ready = !r_busy; // no new command until the reply tail is gone
	assign w_take = i_ctrl_valid && o_ctrl_ready;
	assign w_idx = (i_ctrl.pos inside {gmii_pkt_pkg::POS_HEAD, gmii_pkt_pkg::POS_SINGLE}) ?
		3'd0 : r_cnt;
	assign w_req = {r_req_hi, i_ctrl.data}; // valid while beat 3 is on the bus
	assign w_ok = w_req.addr < 20'(gmii_pkt_pkg::REG_COUNT);
	assign w_exec = w_take && (i_ctrl.pos == gmii_pkt_pkg::POS_TAIL) &&
		(w_idx == 3'(gmii_pkt_pkg::CTRL_BEATS - 1)); // any other length is dropped

	// ------------------------------------------------------------------------
	// command side
	// ------------------------------------------------------------------------
	always_ff @(posedge i_sys_clk) begin
		if (i_reset) begin
			r_cnt <= '0;
			for (int i = 0; i < gmii_pkt_pkg::REG_COUNT; i++)
				r_regs[i] <= '0;
		end else begin
			if (w_take)
				r_cnt <= (w_idx == 3'd7) ? 3'd7 : w_idx + 3'd1;
			if (w_exec && w_req.write && w_ok)
				r_regs[w_req.addr[gmii_pkt_pkg::REG_ADDR_W-1:0]] <= w_req.data;
		end
	end

	always_ff @(posedge i_sys_clk) begin
		if (w_take && w_idx == 3'd2)
			r_req_hi <= i_ctrl.data; // seq, flags, mdid, addr
		if (w_exec) begin
			r_res.seq <= w_req.seq;
			r_res.ok <= w_ok;
			r_res.write <= w_req.write;
			r_res.mdid <= w_req.mdid;
			r_res.addr <= w_req.addr;
			if (w_req.write)
				r_res.data <= w_req.data; // write echoes its data
			else
				r_res.data <= w_ok ? r_regs[w_req.addr[gmii_pkt_pkg::REG_ADDR_W-1:0]] : '0;
		end
	end

	// ------------------------------------------------------------------------
	// reply side
	// ------------------------------------------------------------------------
	assign o_reply_valid = r_busy;

	always_ff @(posedge i_sys_clk) begin
		if (i_reset) begin
			r_busy <= 1'b0;
			r_rcnt <= '0;
		end else if (w_exec) begin
			r_busy <= 1'b1;
			r_rcnt <= '0;
		end else if (r_busy && i_reply_ready) begin
			r_rcnt <= r_rcnt + 2'd1;
			if (r_rcnt == 2'(gmii_pkt_pkg::CTRL_BEATS - 1))
				r_busy <= 1'b0; // tail taken
		end
	end

	always_comb begin
		o_reply.pos = gmii_pkt_pkg::POS_BODY;
		o_reply.empty = 2'd0;
		o_reply.data = r_res[31:0];
		case (r_rcnt)
			2'd0: begin
				o_reply.pos = gmii_pkt_pkg::POS_HEAD;
				o_reply.data = gmii_pkt_pkg::HOST_MAC[47:16];
			end
			2'd1: o_reply.data = {gmii_pkt_pkg::HOST_MAC[15:0], 16'h0000};
			2'd2: o_reply.data = r_res[63:32];
			default: o_reply.pos = gmii_pkt_pkg::POS_TAIL;
		endcase
	end

	// a reply only follows a full command and no control beat enters under it
	a_no_overlap: assert property (@(posedge i_sys_clk) disable iff (i_reset)
		o_reply_valid |-> !w_take && (r_cnt == 3'(gmii_pkt_pkg::CTRL_BEATS)));

endmodule

// ==== source/pkt_poll_mux.sv ====
// two port poll mux, merges reply and data packets on packet boundaries
`timescale 1ns/1ps

module pkt_poll_mux (
	input  logic                 i_sys_clk,
	input  logic                 i_reset,
	input  gmii_pkt_pkg::beat_t  i_reply,
	input  logic                 i_reply_valid,
	output logic                 o_reply_ready,
	input  gmii_pkt_pkg::beat_t  i_data,
	input  logic                 i_data_valid,
	output logic                 o_data_ready,
	output gmii_pkt_pkg::beat_t  o_beat,
	output logic                 o_beat_valid,
	input  logic                 i_beat_ready
);

	logic r_grant; // 0 reply, 1 data, last granted port
	logic r_busy;  // packet in flight
	logic w_sel;
	logic w_xfer;
	logic w_end;

	// try the other port first, else stay
	assign w_sel = (r_grant ? i_reply_valid : i_data_valid) ? !r_grant : r_grant;

	assign o_beat = r_grant ? i_data : i_reply;
	assign o_beat_valid = r_busy && (r_grant ? i_data_valid : i_reply_valid);
	assign o_reply_ready = r_busy && !r_grant && i_beat_ready; // only the granted port
	assign o_data_ready = r_busy && r_grant && i_beat_ready;

	assign w_xfer = o_beat_valid && i_beat_ready;
	assign w_end = o_beat.pos inside {gmii_pkt_pkg::POS_TAIL, gmii_pkt_pkg::POS_SINGLE};

	always_ff @(posedge i_sys_clk) begin
		if (i_reset) begin
			r_grant <= 1'b0;
			r_busy <= 1'b0;
		end else if (!r_busy) begin
			if (i_reply_valid || i_data_valid) begin // poll
				r_grant <= w_sel;
				r_busy <= 1'b1;
			end
		end else if (w_xfer && w_end) begin
			r_busy <= 1'b0; // back to polling
		end
	end

	// grant is locked from the poll until the last beat leaves
	a_grant_hold: assert property (@(posedge i_sys_clk) disable iff (i_reset)
		r_busy && !(w_xfer && w_end) |=> r_busy && $stable(r_grant));

endmodule

// ==== source/beat_to_byte_unpacker.sv ====
// tx side width converter, serializes 32-bit beats to bytes and marks the last one
`timescale 1ns/1ps

module beat_to_byte_unpacker (
	input  logic                 i_sys_clk,
	input  logic                 i_reset,
	input  gmii_pkt_pkg::beat_t  i_beat,
	input  logic                 i_beat_valid,
	output logic                 o_beat_ready,
	output gmii_pkt_pkg::byte_t  o_byte,
	output logic                 o_byte_valid,
	input  logic                 i_byte_ready
);

	logic [31:0] r_word; // current beat, next byte on top
	logic [2:0]  r_left; // bytes still to send
	logic        r_tail; // beat closes the packet
	logic        w_byte_take;
	logic        w_beat_take;

	assign o_byte_valid = r_left != 3'd0;
	assign o_byte.data = r_word[31:24];
	assign o_byte.last = r_tail && (r_left == 3'd1);
	assign w_byte_take = o_byte_valid && i_byte_ready;

	// reload as the final byte drains, so no bubble between beats
	assign o_beat_ready = !o_byte_valid || ((r_left == 3'd1) && i_byte_ready);
	assign w_beat_take = i_beat_valid && o_beat_ready;

	always_ff @(posedge i_sys_clk) begin
		if (i_reset)
			r_left <= '0;
		else if (w_beat_take)
			r_left <= 3'(gmii_pkt_pkg::WORD_BYTES - i_beat.empty);
		else if (w_byte_take)
			r_left <= r_left - 3'd1;
	end

	always_ff @(posedge i_sys_clk) begin
		if (w_beat_take) begin
			r_word <= i_beat.data;
			r_tail <= i_beat.pos inside {gmii_pkt_pkg::POS_TAIL, gmii_pkt_pkg::POS_SINGLE};
		end else if (w_byte_take) begin
			r_word <= {r_word[23:0], 8'h00}; // shift next byte up
		end
	end

	// held byte does not move while the sink stalls
	a_stall_stable: assert property (@(posedge i_sys_clk) disable iff (i_reset)
		o_byte_valid && !i_byte_ready |=> o_byte_valid && $stable(o_byte));

endmodule

// ==== source/gmii_pkt_top.sv ====
// top of the packet path, rx bytes in, merged reply and data bytes out
`timescale 1ns/1ps

module gmii_pkt_top (
	input  logic                 i_sys_clk,
	input  logic                 i_reset,
	input  gmii_pkt_pkg::byte_t  i_rx,
	input  logic                 i_rx_valid,
	output logic                 o_rx_ready,
	output gmii_pkt_pkg::byte_t  o_tx,
	output logic                 o_tx_valid,
	input  logic                 i_tx_ready
);

	gmii_pkt_pkg::beat_t rx_beat, ctrl_beat, data_beat, reply_beat, tx_beat;
	logic rx_beat_valid, rx_beat_ready;
	logic ctrl_valid, ctrl_ready;
	logic data_valid, data_ready;
	logic reply_valid, reply_ready;
	logic tx_beat_valid, tx_beat_ready;

	// ------------------------------------------------------------------------
	// rx bytes to beats, then split on the MAC
	// ------------------------------------------------------------------------
	byte_to_beat_packer byte_to_beat_packer_i (
		.i_sys_clk(i_sys_clk), .i_reset(i_reset),
		.i_byte(i_rx), .i_byte_valid(i_rx_valid), .o_byte_ready(o_rx_ready),
		.o_beat(rx_beat), .o_beat_valid(rx_beat_valid), .i_beat_ready(rx_beat_ready));

	pkt_preparser pkt_preparser_i (
		.i_sys_clk(i_sys_clk), .i_reset(i_reset),
		.i_beat(rx_beat), .i_beat_valid(rx_beat_valid), .o_beat_ready(rx_beat_ready),
		.o_ctrl(ctrl_beat), .o_ctrl_valid(ctrl_valid), .i_ctrl_ready(ctrl_ready),
		.o_data(data_beat), .o_data_valid(data_valid), .i_data_ready(data_ready));

	ctrl_cmd_engine ctrl_cmd_engine_i (
		.i_sys_clk(i_sys_clk), .i_reset(i_reset),
		.i_ctrl(ctrl_beat), .i_ctrl_valid(ctrl_valid), .o_ctrl_ready(ctrl_ready),
		.o_reply(reply_beat), .o_reply_valid(reply_valid), .i_reply_ready(reply_ready));

	// replies on port 0, data on port 1
	pkt_poll_mux pkt_poll_mux_i (
		.i_sys_clk(i_sys_clk), .i_reset(i_reset),
		.i_reply(reply_beat), .i_reply_valid(reply_valid), .o_reply_ready(reply_ready),
		.i_data(data_beat), .i_data_valid(data_valid), .o_data_ready(data_ready),
		.o_beat(tx_beat), .o_beat_valid(tx_beat_valid), .i_beat_ready(tx_beat_ready));

	beat_to_byte_unpacker beat_to_byte_unpacker_i (
		.i_sys_clk(i_sys_clk), .i_reset(i_reset),
		.i_beat(tx_beat), .i_beat_valid(tx_beat_valid), .o_beat_ready(tx_beat_ready),
		.o_byte(o_tx), .o_byte_valid(o_tx_valid), .i_byte_ready(i_tx_ready));

endmodule

// ==== verification/gmii_pkt_tb.sv ====
// testbench for gmii_pkt_top, replays the tests file and checks the reply and data streams
`timescale 1ns/1ps

module gmii_pkt_tb;

	logic sys_clk;
	logic reset;
	gmii_pkt_pkg::byte_t rx;
	logic rx_valid;
	logic rx_ready;
	gmii_pkt_pkg::byte_t tx;
	logic tx_valid;
	logic tx_ready;

	gmii_pkt_pkg::byte_t rx_q [$];      // all input bytes, packets back to back
	gmii_pkt_pkg::byte_t exp_data [$];  // expected data stream, last marks packet end
	gmii_pkt_pkg::byte_t exp_reply [$];
	string data_names [$];              // test name per expected packet
	string reply_names [$];
	logic [7:0] got [$];                // output packet being collected
	logic [31:0] lfsr;
	int passes;
	int fails;
	int cycles;
	int limit;
	int rx_idx;
	logic rx_taken;
	logic timed_out;
	logic file_bad;

	gmii_pkt_top gmii_pkt_top_i (
		.i_sys_clk(sys_clk), .i_reset(reset),
		.i_rx(rx), .i_rx_valid(rx_valid), .o_rx_ready(rx_ready),
		.o_tx(tx), .o_tx_valid(tx_valid), .i_tx_ready(tx_ready));

	always #4 sys_clk = !sys_clk; // 8 ns period

	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic take_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr_step(lfsr); // one step per bit used
		return b;
	endfunction

	// ------------------------------------------------------------------------
	// tests file, records of kind, name (inputs only), byte count, hex bytes
	// ------------------------------------------------------------------------
	task automatic read_tests();
		int fd;
		int code;
		int n;
		int val;
		int i;
		logic [127:0] kind;
		logic [127:0] raw_name;
		logic [1023:0] rest;
		string name;
		gmii_pkt_pkg::byte_t b;
		name = "";
		fd = $fopen("verification/gmii_pkt_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open verification/gmii_pkt_tests.txt");
			file_bad = 1'b1;
			return;
		end
		while (!$feof(fd)) begin
			kind = '0;
			code = $fscanf(fd, "%s", kind);
			if (code != 1)
				break; // end of file
			if (kind == "#") begin
				code = $fgets(rest, fd); // skip comment
			end else if (kind == "in" || kind == "data" || kind == "reply") begin
				if (kind == "in") begin
					raw_name = '0;
					code = $fscanf(fd, "%s", raw_name);
					name = string'(raw_name); // outputs inherit this name
				end
				code = $fscanf(fd, "%d", n);
				if (kind == "data")
					data_names.push_back(name);
				if (kind == "reply")
					reply_names.push_back(name);
				for (i = 0; i < n; i++) begin
					code = $fscanf(fd, "%h", val);
					if (code != 1)
						file_bad = 1'b1;
					b.data = val[7:0];
					b.last = (i == n - 1);
					if (kind == "in")
						rx_q.push_back(b);
					else if (kind == "data")
						exp_data.push_back(b);
					else
						exp_reply.push_back(b);
				end
			end else begin
				$display("unknown record in the tests file after test %0s", name);
				file_bad = 1'b1;
				break;
			end
		end
		$fclose(fd);
	endtask

	// ------------------------------------------------------------------------
	// sort a finished output packet by its dst MAC and compare it
	// ------------------------------------------------------------------------
	task automatic check_packet();
		logic [47:0] mac;
		logic is_reply;
		logic bad;
		int i;
		string name;
		string kind;
		gmii_pkt_pkg::byte_t ent;
		logic [7:0] want [$];
		mac = '0;
		bad = 1'b0;
		for (i = 0; i < 6 && i < got.size(); i++)
			mac = {mac[39:0], got[i]};
		is_reply = (got.size() >= 6) && (mac == gmii_pkt_pkg::HOST_MAC);
		kind = is_reply ? "reply" : "data";
		if (is_reply ? reply_names.size() == 0 : data_names.size() == 0) begin
			$display("an unexpected %0s packet of %0d bytes came out", kind, got.size());
			fails++;
		end else begin
			name = is_reply ? reply_names.pop_front() : data_names.pop_front();
			do begin
				ent = is_reply ? exp_reply.pop_front() : exp_data.pop_front();
				want.push_back(ent.data);
			end while (!ent.last);
			assert (got.size() == want.size()) else begin
				$display("[ERROR] %0s length expected %0d actual %0d", name, want.size(),
					got.size());
				bad = 1'b1;
			end
			for (i = 0; i < want.size() && i < got.size(); i++)
				assert (got[i] == want[i]) else begin
					$display("[ERROR] %0s byte %0d expected %02h actual %02h", name, i,
						want[i], got[i]);
					bad = 1'b1;
				end
			if (bad)
				fails++;
			else
				passes++;
			$display("%0s %0s %0s, %0d bytes", name, kind, bad ? "FAILED" : "ok", got.size());
		end
		got.delete();
	endtask

	initial begin
		sys_clk = 1'b0;
		reset = 1'b1;
		rx = '0;
		rx_valid = 1'b0;
		tx_ready = 1'b0;
		lfsr = 32'h5b91_50dc;
		passes = 0;
		fails = 0;
		cycles = 0;
		rx_idx = 0;
		rx_taken = 1'b0;
		timed_out = 1'b0;
		file_bad = 1'b0;
		read_tests();
		limit = 30 * rx_q.size() + 500;
		repeat (10) @(posedge sys_clk);
		#1 reset = 1'b0;

		// drive 1 ns after the edge, sample at the falling edge
		while (!(rx_idx == rx_q.size() && data_names.size() == 0 && reply_names.size() == 0)
			&& !timed_out) begin
			@(posedge sys_clk);
			#1;
			if (!(rx_valid && !rx_taken)) begin // a held byte stays put
				if (rx_idx < rx_q.size()) begin
					rx = rx_q[rx_idx];
					rx_valid = !(take_bit() & take_bit()); // gap one in four
				end else begin
					rx_valid = 1'b0;
				end
			end
			tx_ready = !(take_bit() & take_bit());
			@(negedge sys_clk);
			rx_taken = rx_valid && rx_ready;
			if (rx_taken)
				rx_idx++;
			if (tx_valid && tx_ready) begin
				got.push_back(tx.data);
				if (tx.last)
					check_packet();
			end
			cycles++;
			if (cycles > limit)
				timed_out = 1'b1;
		end
		rx_valid = 1'b0;

		if (timed_out)
			$display("timeout after %0d cycles with %0d of %0d input bytes sent", cycles,
				rx_idx, rx_q.size());
		if (data_names.size() != 0 || reply_names.size() != 0) begin
			$display("%0d data and %0d reply packets never came out", data_names.size(),
				reply_names.size());
			fails += data_names.size() + reply_names.size();
		end
		$display("%0d tests, %0d passed, %0d failed", passes + fails, passes, fails);
		if (fails == 0 && passes > 0 && !timed_out && !file_bad) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== verification/gmii_pkt_tests.txt ====
# kind name count bytes: "in" is an input packet, "data" and "reply" the output packets it causes
# control packets go to 88:88:88:88:88:88, replies come back to 00:00:5e:00:01:01
in d7 7 02 11 22 33 44 55 a0
data 7 02 11 22 33 44 55 a0
in d8 8 02 11 22 33 44 66 08 00
data 8 02 11 22 33 44 66 08 00
in d13 13 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16
data 13 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16
in wr3 16 88 88 88 88 88 88 08 00 89 50 00 03 de ad be ef
reply 16 00 00 5e 00 01 01 00 00 99 50 00 03 de ad be ef
in rd3 16 88 88 88 88 88 88 08 00 82 a0 00 03 00 00 00 00
reply 16 00 00 5e 00 01 01 00 00 92 a0 00 03 de ad be ef
in rd40 16 88 88 88 88 88 88 08 00 80 70 00 28 12 34 56 78
reply 16 00 00 5e 00 01 01 00 00 80 70 00 28 00 00 00 00
in ctl12 12 88 88 88 88 88 88 08 00 89 50 00 05
in wr5 16 88 88 88 88 88 88 08 00 88 10 00 05 0b ad f0 0d
reply 16 00 00 5e 00 01 01 00 00 98 10 00 05 0b ad f0 0d
in s5 5 88 88 88 88 88
data 5 88 88 88 88 88
in s3 3 c1 c2 c3
data 3 c1 c2 c3

// ==== gmii_pkt.f ====
source/gmii_pkt_pkg.sv
source/byte_to_beat_packer.sv
source/pkt_preparser.sv
source/ctrl_cmd_engine.sv
source/pkt_poll_mux.sv
source/beat_to_byte_unpacker.sv
source/gmii_pkt_top.sv
verification/gmii_pkt_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the gmii_pkt testbench with Verilator, pass only if the log says so
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module gmii_pkt_tb \
	-f gmii_pkt.f -o gmii_pkt_sim

./obj_dir/gmii_pkt_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
	exit 0
fi
exit 1
